/* design/mem_pkg.sv */
// Shared SRAM types and fixed region map; main memory decodes only address bits 16:0
package mem_pkg;

   typedef logic [17:0] sram_addr_t;   // SRAM word address, 256K words
   typedef logic [31:0] sram_word_t;   // Full word, high half on chip 2
   typedef logic [15:0] sram_half_t;   // One chip's data bus
   typedef logic [21:0] mm_addr_t;     // CPU main-memory address
   typedef logic [14:0] vram_addr_t;   // Video-memory address
   typedef logic [13:0] mcr_addr_t;    // Microcode address
   typedef logic [48:0] mcr_word_t;    // Microcode word, widest payload

   localparam int MCR_HI_W = 17;       // Microcode bits 48:32 in word 1

   // Requesters, values double as priority rank (VGA first)
   typedef enum logic [1:0] {
      PORT_VGA  = 2'd0,
      PORT_MCR  = 2'd1,
      PORT_VCPU = 2'd2,
      PORT_MM   = 2'd3
   } port_id_t;

   typedef struct packed {
      port_id_t   port;       // Who gets the response
      logic       write;      // 1 = store, 0 = load
      sram_addr_t addr;       // Already mapped into the port's region
      mcr_word_t  wdata;      // 32-bit ports zero-extended
      logic       two_word;   // Microcode, two SRAM words
   } mem_req_t;

   typedef struct packed {
      port_id_t  port;        // Tag copied from the request
      mcr_word_t rdata;       // Low 32 bits for one-word ports
   } mem_rsp_t;

   // Region tags in the top SRAM address bits
   localparam logic       REGION_MM   = 1'b0;
   localparam logic [1:0] REGION_VRAM = 2'b10;
   localparam logic [1:0] REGION_MCR  = 2'b11;

   // Main memory, lower half of the SRAM
   function automatic sram_addr_t map_mm(mm_addr_t addr);
      return {REGION_MM, addr[16:0]};   // Bits 21:17 dropped
   endfunction

   // Video memory, shared by CPU and display ports
   function automatic sram_addr_t map_vram(vram_addr_t addr);
      return {REGION_VRAM, addr, 1'b0};   // Spare low bit kept zero
   endfunction

   // Microcode, word-select in bit 0 starts at word 0
   function automatic sram_addr_t map_mcr(mcr_addr_t addr);
      return {REGION_MCR, 1'b0, addr, 1'b0};   // Bit 15 spare
   endfunction

endpackage

/* design/port_mux.sv */
// Fixed priority VGA > MCR > VCPU > MM with no fairness; one hold entry, done one cycle after rsp
`timescale 1ns/1ps

module port_mux (
   input  logic                 uhdl_common,
   input  logic                 reset,

   input  logic                 vram_vga_req,
   input  mem_pkg::vram_addr_t  vram_vga_addr,
   output logic                 vram_vga_ready,
   output logic                 vram_vga_done,
   output mem_pkg::sram_word_t  vram_vga_data_out,

   input  logic                 mcr_req,
   input  logic                 mcr_write,
   input  mem_pkg::mcr_addr_t   mcr_addr,
   input  mem_pkg::mcr_word_t   mcr_data_in,
   output logic                 mcr_ready,
   output logic                 mcr_done,
   output mem_pkg::mcr_word_t   mcr_data_out,

   input  logic                 vram_cpu_req,
   input  logic                 vram_cpu_write,
   input  mem_pkg::vram_addr_t  vram_cpu_addr,
   input  mem_pkg::sram_word_t  vram_cpu_data_in,
   output logic                 vram_cpu_ready,
   output logic                 vram_cpu_done,
   output mem_pkg::sram_word_t  vram_cpu_data_out,

   input  logic                 sdram_req,
   input  logic                 sdram_write,
   input  mem_pkg::mm_addr_t    sdram_addr,
   input  mem_pkg::sram_word_t  sdram_data_in,
   output logic                 sdram_ready,
   output logic                 sdram_done,
   output mem_pkg::sram_word_t  sdram_data_out,

   output mem_pkg::mem_req_t    seq_req,
   output logic                 seq_valid,
   input  logic                 seq_ready,
   input  mem_pkg::mem_rsp_t    seq_rsp,
   input  logic                 seq_rsp_valid
);

   import mem_pkg::*;

   logic [3:0] grant;        // One-hot winner, indexed by port_id_t
   logic       can_load;     // Hold entry free this cycle
   logic       load;         // A port handshakes now
   logic       hold_valid;   // Entry waiting for the sequencer
   mem_req_t   hold_q;       // The one-entry hold register
   mem_req_t   sel_req;      // Winner's request, region mapped
   logic [3:0] done_q;       // Registered done pulses
   logic       in_flight;    // Sequencer owns a request

   // Free, or being drained by the sequencer in this cycle
   assign can_load = !hold_valid || seq_ready;
   assign load     = can_load && (grant != 4'b0000);

   // Priority pick and address mapping
   always_comb begin
      grant   = 4'b0000;
      sel_req = '0;   // Read, one word, zero data by default
      if (vram_vga_req) begin
         grant[PORT_VGA] = 1'b1;
         sel_req.port    = PORT_VGA;
         sel_req.addr    = map_vram(vram_vga_addr);   // Display is read only
      end else if (mcr_req) begin
         grant[PORT_MCR]  = 1'b1;
         sel_req.port     = PORT_MCR;
         sel_req.write    = mcr_write;
         sel_req.addr     = map_mcr(mcr_addr);
         sel_req.wdata    = mcr_data_in;
         sel_req.two_word = 1'b1;   // 49 bits need two SRAM words
      end else if (vram_cpu_req) begin
         grant[PORT_VCPU] = 1'b1;
         sel_req.port     = PORT_VCPU;
         sel_req.write    = vram_cpu_write;
         sel_req.addr     = map_vram(vram_cpu_addr);
         sel_req.wdata    = {{MCR_HI_W{1'b0}}, vram_cpu_data_in};
      end else if (sdram_req) begin
         grant[PORT_MM] = 1'b1;
         sel_req.port   = PORT_MM;
         sel_req.write  = sdram_write;
         sel_req.addr   = map_mm(sdram_addr);
         sel_req.wdata  = {{MCR_HI_W{1'b0}}, sdram_data_in};
      end
   end

   assign vram_vga_ready = can_load && grant[PORT_VGA];
   assign mcr_ready      = can_load && grant[PORT_MCR];
   assign vram_cpu_ready = can_load && grant[PORT_VCPU];
   assign sdram_ready    = can_load && grant[PORT_MM];

   // Hold register control
   always_ff @(posedge uhdl_common) begin
      if (reset) begin
         hold_valid <= 1'b0;
      end else begin
         hold_valid <= load || (hold_valid && !seq_ready);   // Refill or keep waiting
      end
   end

   always_ff @(posedge uhdl_common) begin
      if (load) begin
         hold_q <= sel_req;   // Payload, no reset
      end
   end

   assign seq_req   = hold_q;
   assign seq_valid = hold_valid;

   // Tracks the request inside the sequencer
   always_ff @(posedge uhdl_common) begin
      if (reset) begin
         in_flight <= 1'b0;
      end else if (seq_valid && seq_ready) begin
         in_flight <= 1'b1;   // New accept wins over a same-cycle rsp
      end else if (seq_rsp_valid) begin
         in_flight <= 1'b0;
      end
   end

   // Response demux into done pulses
   always_ff @(posedge uhdl_common) begin
      if (reset) begin
         done_q <= 4'b0000;
      end else begin
         done_q <= 4'b0000;   // One-cycle pulses
         if (seq_rsp_valid) begin
            done_q[seq_rsp.port] <= 1'b1;
         end
      end
   end

   // Read data, held until the port's next response
   always_ff @(posedge uhdl_common) begin
      if (seq_rsp_valid) begin
         case (seq_rsp.port)
            PORT_VGA:  vram_vga_data_out <= seq_rsp.rdata[31:0];
            PORT_MCR:  mcr_data_out      <= seq_rsp.rdata;
            PORT_VCPU: vram_cpu_data_out <= seq_rsp.rdata[31:0];
            PORT_MM:   sdram_data_out    <= seq_rsp.rdata[31:0];
            default:   ;
         endcase
      end
   end

   assign vram_vga_done = done_q[PORT_VGA];
   assign mcr_done      = done_q[PORT_MCR];
   assign vram_cpu_done = done_q[PORT_VCPU];
   assign sdram_done    = done_q[PORT_MM];

   // A port's handshake is exclusive
   a_one_ready: assert property (@(posedge uhdl_common) disable iff (reset)
      $onehot0({vram_vga_ready, mcr_ready, vram_cpu_ready, sdram_ready}))
      else $error("More than one port ready in a cycle");

   // Sequencer only answers what it took from here
   a_rsp_owned: assert property (@(posedge uhdl_common) disable iff (reset)
      seq_rsp_valid |-> in_flight)
      else $error("Response with no request in flight");

endmodule

/* design/sram_sequencer.sv */
// Async SRAM strobe sequencer; sram_wait >= 1, both chips always enabled together
`timescale 1ns/1ps

module sram_sequencer #(
   parameter int sram_wait = 2   // Strobe low time in cycles
) (
   input  logic                 uhdl_common,
   input  logic                 reset,

   input  mem_pkg::mem_req_t    seq_req,
   input  logic                 seq_valid,
   output logic                 seq_ready,
   output mem_pkg::mem_rsp_t    seq_rsp,
   output logic                 seq_rsp_valid,

   output mem_pkg::sram_addr_t  sram_a,
   input  mem_pkg::sram_half_t  sram1_in,
   input  mem_pkg::sram_half_t  sram2_in,
   output mem_pkg::sram_half_t  sram1_out,
   output mem_pkg::sram_half_t  sram2_out,
   output logic                 sram_we_n,
   output logic                 sram_oe_n,
   output logic                 sram1_ce_n,
   output logic                 sram2_ce_n
);

   import mem_pkg::*;

   localparam int CNT_W = (sram_wait > 1) ? $clog2(sram_wait) : 1;
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(sram_wait - 1);

   typedef enum logic [1:0] {
      SEQ_IDLE,        // Address of a pending request already on the pins
      SEQ_STROBE,      // WE or OE low
      SEQ_RECOVER,     // Strobe high, response goes out next
      SEQ_NEXT_WORD    // Recovery of word 0, setup of word 1
   } seq_state_t;

   seq_state_t                  state;
   mem_req_t                    req_q;        // Accepted request
   mem_req_t                    cur_req;      // What the pins show
   logic                        word_sel;     // Second microcode word
   logic [CNT_W-1:0]            cnt;          // Strobe cycles so far
   logic                        strobe_end;   // Last strobe cycle
   logic                        accept;
   logic                        we_n_q;
   logic                        oe_n_q;
   logic                        ce_n_q;
   sram_word_t                  wr_word;      // Data bus for this word
   sram_word_t                  rd_word;      // Both chips joined
   sram_word_t                  lo_q;         // Word 0 read data
   logic [MCR_HI_W-1:0]         hi_q;         // Word 1 read data, microcode only

   assign seq_ready  = (state == SEQ_IDLE);
   assign accept     = seq_valid && seq_ready;
   assign strobe_end = (state == SEQ_STROBE) && (cnt == CNT_LAST);

   // In idle the held request drives the pins, a cycle ahead of the strobe
   assign cur_req = (state == SEQ_IDLE) ? seq_req : req_q;
   assign sram_a  = {cur_req.addr[17:1], cur_req.addr[0] | word_sel};
   assign wr_word = word_sel ? {15'b0, cur_req.wdata[48:32]} : cur_req.wdata[31:0];

   assign sram1_out  = wr_word[15:0];
   assign sram2_out  = wr_word[31:16];   // High half on chip 2
   assign rd_word    = {sram2_in, sram1_in};
   assign sram_we_n  = we_n_q;
   assign sram_oe_n  = oe_n_q;
   assign sram1_ce_n = ce_n_q;
   assign sram2_ce_n = ce_n_q;

   // FSM and strobes
   always_ff @(posedge uhdl_common) begin
      if (reset) begin
         state         <= SEQ_IDLE;
         word_sel      <= 1'b0;
         cnt           <= '0;
         we_n_q        <= 1'b1;
         oe_n_q        <= 1'b1;
         ce_n_q        <= 1'b1;
         seq_rsp_valid <= 1'b0;
      end else begin
         seq_rsp_valid <= 1'b0;   // Single-cycle pulse
         case (state)
            SEQ_IDLE: begin
               if (accept) begin
                  ce_n_q   <= 1'b0;
                  we_n_q   <= !seq_req.write;
                  oe_n_q   <= seq_req.write;
                  cnt      <= '0;
                  word_sel <= 1'b0;
                  state    <= SEQ_STROBE;
               end
            end
            SEQ_STROBE: begin
               if (strobe_end) begin
                  we_n_q <= 1'b1;
                  oe_n_q <= 1'b1;
                  if (req_q.two_word && !word_sel) begin
                     word_sel <= 1'b1;   // Address moves to word 1
                     state    <= SEQ_NEXT_WORD;
                  end else begin
                     state <= SEQ_RECOVER;
                  end
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            SEQ_NEXT_WORD: begin
               we_n_q <= !req_q.write;   // Same direction as word 0
               oe_n_q <= req_q.write;
               cnt    <= '0;
               state  <= SEQ_STROBE;
            end
            SEQ_RECOVER: begin
               ce_n_q        <= 1'b1;
               word_sel      <= 1'b0;
               seq_rsp_valid <= 1'b1;
               state         <= SEQ_IDLE;
            end
            default: state <= SEQ_IDLE;
         endcase
      end
   end

   // Request copy, read capture and response payload
   always_ff @(posedge uhdl_common) begin
      if (accept) begin
         req_q <= seq_req;
      end
      if (strobe_end && !word_sel) begin
         lo_q <= rd_word;   // Sampled as the strobe rises
      end
      if (strobe_end && word_sel) begin
         hi_q <= rd_word[MCR_HI_W-1:0];
      end
      if (state == SEQ_RECOVER) begin
         seq_rsp.port  <= req_q.port;
         seq_rsp.rdata <= req_q.two_word ? {hi_q, lo_q} : {{MCR_HI_W{1'b0}}, lo_q};
      end
   end

   // Never drive the bus against the chips
   a_no_contention: assert property (@(posedge uhdl_common) disable iff (reset)
      !(!sram_we_n && !sram_oe_n))
      else $error("WE and OE low together");

   // Address set up before and held through every strobe cycle
   a_addr_stable: assert property (@(posedge uhdl_common) disable iff (reset)
      (!sram_we_n || !sram_oe_n) |-> $stable(sram_a))
      else $error("SRAM address changed under a strobe");

endmodule

/* design/ram_controller.sv */
// Four-port SRAM controller top; single clock, responses have no back-pressure
`timescale 1ns/1ps

module ram_controller #(
   parameter int sram_wait = 2   // Passed to the sequencer, 1 or more
) (
   input  logic                 uhdl_common,
   input  logic                 reset,

   input  logic                 vram_vga_req,
   input  mem_pkg::vram_addr_t  vram_vga_addr,
   output logic                 vram_vga_ready,
   output logic                 vram_vga_done,
   output mem_pkg::sram_word_t  vram_vga_data_out,

   input  logic                 mcr_req,
   input  logic                 mcr_write,
   input  mem_pkg::mcr_addr_t   mcr_addr,
   input  mem_pkg::mcr_word_t   mcr_data_in,
   output logic                 mcr_ready,
   output logic                 mcr_done,
   output mem_pkg::mcr_word_t   mcr_data_out,

   input  logic                 vram_cpu_req,
   input  logic                 vram_cpu_write,
   input  mem_pkg::vram_addr_t  vram_cpu_addr,
   input  mem_pkg::sram_word_t  vram_cpu_data_in,
   output logic                 vram_cpu_ready,
   output logic                 vram_cpu_done,
   output mem_pkg::sram_word_t  vram_cpu_data_out,

   input  logic                 sdram_req,
   input  logic                 sdram_write,
   input  mem_pkg::mm_addr_t    sdram_addr,
   input  mem_pkg::sram_word_t  sdram_data_in,
   output logic                 sdram_ready,
   output logic                 sdram_done,
   output mem_pkg::sram_word_t  sdram_data_out,

   output mem_pkg::sram_addr_t  sram_a,
   input  mem_pkg::sram_half_t  sram1_in,
   input  mem_pkg::sram_half_t  sram2_in,
   output mem_pkg::sram_half_t  sram1_out,
   output mem_pkg::sram_half_t  sram2_out,
   output logic                 sram_we_n,
   output logic                 sram_oe_n,
   output logic                 sram1_ce_n,
   output logic                 sram2_ce_n
);

   import mem_pkg::*;

   mem_req_t seq_req;         // Hold register to sequencer
   logic     seq_valid;
   logic     seq_ready;
   mem_rsp_t seq_rsp;         // Tagged read data back
   logic     seq_rsp_valid;

   port_mux i_port_mux (
      .uhdl_common       (uhdl_common),
      .reset             (reset),
      .vram_vga_req      (vram_vga_req),
      .vram_vga_addr     (vram_vga_addr),
      .vram_vga_ready    (vram_vga_ready),
      .vram_vga_done     (vram_vga_done),
      .vram_vga_data_out (vram_vga_data_out),
      .mcr_req           (mcr_req),
      .mcr_write         (mcr_write),
      .mcr_addr          (mcr_addr),
      .mcr_data_in       (mcr_data_in),
      .mcr_ready         (mcr_ready),
      .mcr_done          (mcr_done),
      .mcr_data_out      (mcr_data_out),
      .vram_cpu_req      (vram_cpu_req),
      .vram_cpu_write    (vram_cpu_write),
      .vram_cpu_addr     (vram_cpu_addr),
      .vram_cpu_data_in  (vram_cpu_data_in),
      .vram_cpu_ready    (vram_cpu_ready),
      .vram_cpu_done     (vram_cpu_done),
      .vram_cpu_data_out (vram_cpu_data_out),
      .sdram_req         (sdram_req),
      .sdram_write       (sdram_write),
      .sdram_addr        (sdram_addr),
      .sdram_data_in     (sdram_data_in),
      .sdram_ready       (sdram_ready),
      .sdram_done        (sdram_done),
      .sdram_data_out    (sdram_data_out),
      .seq_req           (seq_req),
      .seq_valid         (seq_valid),
      .seq_ready         (seq_ready),
      .seq_rsp           (seq_rsp),
      .seq_rsp_valid     (seq_rsp_valid)
   );

   sram_sequencer #(
      .sram_wait (sram_wait)
   ) i_sram_sequencer (
      .uhdl_common   (uhdl_common),
      .reset         (reset),
      .seq_req       (seq_req),
      .seq_valid     (seq_valid),
      .seq_ready     (seq_ready),
      .seq_rsp       (seq_rsp),
      .seq_rsp_valid (seq_rsp_valid),
      .sram_a        (sram_a),
      .sram1_in      (sram1_in),
      .sram2_in      (sram2_in),
      .sram1_out     (sram1_out),
      .sram2_out     (sram2_out),
      .sram_we_n     (sram_we_n),
      .sram_oe_n     (sram_oe_n),
      .sram1_ce_n    (sram1_ce_n),
      .sram2_ce_n    (sram2_ce_n)
   );

endmodule

/* verification/sram_model.sv */
// Behavioral async SRAM, 256K words on two 16-bit chips; writes land 1 ns after pins settle
`timescale 1ns/1ps

module sram_model (
   input  mem_pkg::sram_addr_t  a,
   input  mem_pkg::sram_half_t  d1,      // Chip 1 write data, low half
   input  mem_pkg::sram_half_t  d2,      // Chip 2 write data, high half
   output mem_pkg::sram_half_t  q1,
   output mem_pkg::sram_half_t  q2,
   input  logic                 we_n,
   input  logic                 oe_n,
   input  logic                 ce1_n,
   input  logic                 ce2_n
);

   import mem_pkg::*;

   sram_half_t mem1 [0:262143];   // Chip 1 cells
   sram_half_t mem2 [0:262143];   // Chip 2 cells

   // Read path follows the address with no delay
   assign q1 = (!ce1_n && !oe_n) ? mem1[a] : 'x;
   assign q2 = (!ce2_n && !oe_n) ? mem2[a] : 'x;

   // Cells take the data bus while WE and CE are low
   always begin
      @(a or d1 or d2 or we_n or ce1_n or ce2_n);
      #1;   // Pins settled, same-edge glitches gone
      if (!we_n && !ce1_n) begin
         mem1[a] = d1;
      end
      if (!we_n && !ce2_n) begin
         mem2[a] = d2;
      end
   end

endmodule

/* verification/ram_controller_tb.sv */
// Self-checking testbench for sram_wait 2; SRAM lives in sram_model, run stops after 4000 cycles
`timescale 1ns/1ps

module ram_controller_tb;

   import mem_pkg::*;

   localparam int SRAM_WAIT   = 2;
   localparam int CYCLE_LIMIT = 4000;   // About 600 cycles of traffic, wide margin
   localparam int MM_N        = 16;     // Main-memory words in test 2
   localparam int MCR_N       = 8;      // Microcode words in test 4

   logic        uhdl_common;
   logic        reset;
   logic [3:0]  req_vec;                // Port requests, indexed by port_id_t
   logic [3:0]  ready_vec;
   logic [3:0]  done_vec;

   logic        vram_vga_req;
   vram_addr_t  vram_vga_addr;
   logic        vram_vga_ready;
   logic        vram_vga_done;
   sram_word_t  vram_vga_data_out;
   logic        mcr_req;
   logic        mcr_write;
   mcr_addr_t   mcr_addr;
   mcr_word_t   mcr_data_in;
   logic        mcr_ready;
   logic        mcr_done;
   mcr_word_t   mcr_data_out;
   logic        vram_cpu_req;
   logic        vram_cpu_write;
   vram_addr_t  vram_cpu_addr;
   sram_word_t  vram_cpu_data_in;
   logic        vram_cpu_ready;
   logic        vram_cpu_done;
   sram_word_t  vram_cpu_data_out;
   logic        sdram_req;
   logic        sdram_write;
   mm_addr_t    sdram_addr;
   sram_word_t  sdram_data_in;
   logic        sdram_ready;
   logic        sdram_done;
   sram_word_t  sdram_data_out;
   sram_addr_t  sram_a;
   sram_half_t  sram1_in;
   sram_half_t  sram2_in;
   sram_half_t  sram1_out;
   sram_half_t  sram2_out;
   logic        sram_we_n;
   logic        sram_oe_n;
   logic        sram1_ce_n;
   logic        sram2_ce_n;

   sram_word_t       mm_shadow [0:131071];   // Indexed by address bits 16:0
   sram_word_t       vram_shadow [0:32767];  // Shared by both video ports
   mcr_word_t        mcr_shadow [0:16383];
   logic [3:0][48:0] exp_data;               // Expected read data per port
   logic [3:0]       chk;                    // Next done carries read data
   logic             quiet_chk;              // Idle window after reset
   logic             order_chk;              // Four-port race window
   logic [1:0]       next_rank;              // Port whose done is due next
   int               done_cnt [4];
   int               sent_cnt [4];
   int               cycles = 0;
   int               errors;
   int               tests_run;
   int               tests_failed;
   int               mark;
   mm_addr_t         mm_list [MM_N];
   mcr_addr_t        mcr_list [MCR_N];
   mm_addr_t         va;                     // Shared video address

   assign vram_vga_req = req_vec[PORT_VGA];
   assign mcr_req      = req_vec[PORT_MCR];
   assign vram_cpu_req = req_vec[PORT_VCPU];
   assign sdram_req    = req_vec[PORT_MM];
   assign ready_vec    = {sdram_ready, vram_cpu_ready, mcr_ready, vram_vga_ready};
   assign done_vec     = {sdram_done, vram_cpu_done, mcr_done, vram_vga_done};

   ram_controller #(
      .sram_wait (SRAM_WAIT)
   ) i_ram_controller (.*);

   sram_model i_sram_model (
      .a     (sram_a),
      .d1    (sram1_out),
      .d2    (sram2_out),
      .q1    (sram1_in),
      .q2    (sram2_in),
      .we_n  (sram_we_n),
      .oe_n  (sram_oe_n),
      .ce1_n (sram1_ce_n),
      .ce2_n (sram2_ce_n)
   );

   initial uhdl_common = 1'b0;
   always #10 uhdl_common = !uhdl_common;   // 20 ns period

   always @(posedge uhdl_common) begin
      cycles <= cycles + 1;
      if (cycles == CYCLE_LIMIT) begin
         $display("Timeout: a transfer did not finish within %0d cycles", CYCLE_LIMIT);
         $display("TESTS FAILED");
         $finish;
      end
   end

   // Completed transfers per port, and the rank due next in the race
   always @(posedge uhdl_common) begin
      for (int i = 0; i < 4; i++) begin
         if (reset) begin
            done_cnt[i] <= 0;
         end else if (done_vec[i]) begin
            done_cnt[i] <= done_cnt[i] + 1;
         end
      end
      if (!order_chk) begin
         next_rank <= 2'd0;
      end else if (done_vec != 4'b0000) begin
         next_rank <= next_rank + 2'd1;
      end
   end

   task automatic note_mismatch(input string name, input mcr_word_t got, input mcr_word_t want);
      errors++;
      $display("Mismatch %s at %0t: got %h, expected %h", name, $time, got, want);
   endtask

   task automatic note_failure(input string what);
      errors++;
      $display("Error at %0t: %s", $time, what);
   endtask

   a_vga_data: assert property (@(posedge uhdl_common) disable iff (reset)
      vram_vga_done && chk[PORT_VGA] |-> vram_vga_data_out == exp_data[PORT_VGA][31:0])
      else note_mismatch("vram_vga_data_out", 49'(vram_vga_data_out), exp_data[PORT_VGA]);

   a_mcr_data: assert property (@(posedge uhdl_common) disable iff (reset)
      mcr_done && chk[PORT_MCR] |-> mcr_data_out == exp_data[PORT_MCR])
      else note_mismatch("mcr_data_out", mcr_data_out, exp_data[PORT_MCR]);

   a_vcpu_data: assert property (@(posedge uhdl_common) disable iff (reset)
      vram_cpu_done && chk[PORT_VCPU] |-> vram_cpu_data_out == exp_data[PORT_VCPU][31:0])
      else note_mismatch("vram_cpu_data_out", 49'(vram_cpu_data_out), exp_data[PORT_VCPU]);

   a_mm_data: assert property (@(posedge uhdl_common) disable iff (reset)
      sdram_done && chk[PORT_MM] |-> sdram_data_out == exp_data[PORT_MM][31:0])
      else note_mismatch("sdram_data_out", 49'(sdram_data_out), exp_data[PORT_MM]);

   a_quiet: assert property (@(posedge uhdl_common) disable iff (reset)
      quiet_chk |-> ready_vec == 4'b0000 && done_vec == 4'b0000 && sram_we_n && sram_oe_n
         && sram1_ce_n && sram2_ce_n)
      else note_failure("ready, done or an SRAM strobe active with no request");

   a_order: assert property (@(posedge uhdl_common) disable iff (reset)
      order_chk && done_vec != 4'b0000 |-> done_vec == (4'b0001 << next_rank))
      else note_failure("done pulses left priority order");

   // Ports below the ready one rank higher and must be idle
   a_priority: assert property (@(posedge uhdl_common) disable iff (reset)
      ready_vec != 4'b0000 |-> (req_vec & (ready_vec - 4'b0001)) == 4'b0000)
      else note_failure("ready given past a higher-priority request");

   function automatic mcr_word_t random_word32();
      return {17'h0, $urandom()};
   endfunction

   function automatic mcr_word_t random_word49();
      return {17'($urandom()), $urandom()};
   endfunction

   // Port fields, shadow update and expected data; req stays low
   task automatic prepare(input port_id_t p, input logic wr, input mm_addr_t addr,
                          input mcr_word_t data);
      case (p)
         PORT_VGA: begin
            vram_vga_addr      = addr[14:0];
            exp_data[PORT_VGA] = 49'(vram_shadow[addr[14:0]]);
            chk[PORT_VGA]      = 1'b1;   // Display only reads
         end
         PORT_MCR: begin
            mcr_write   = wr;
            mcr_addr    = addr[13:0];
            mcr_data_in = data;
            if (wr) begin
               mcr_shadow[addr[13:0]] = data;
            end
            exp_data[PORT_MCR] = mcr_shadow[addr[13:0]];
            chk[PORT_MCR]      = !wr;
         end
         PORT_VCPU: begin
            vram_cpu_write   = wr;
            vram_cpu_addr    = addr[14:0];
            vram_cpu_data_in = data[31:0];
            if (wr) begin
               vram_shadow[addr[14:0]] = data[31:0];
            end
            exp_data[PORT_VCPU] = 49'(vram_shadow[addr[14:0]]);
            chk[PORT_VCPU]      = !wr;
         end
         default: begin
            sdram_write   = wr;
            sdram_addr    = addr;   // Bits 21:17 not decoded
            sdram_data_in = data[31:0];
            if (wr) begin
               mm_shadow[addr[16:0]] = data[31:0];
            end
            exp_data[PORT_MM] = 49'(mm_shadow[addr[16:0]]);
            chk[PORT_MM]      = !wr;
         end
      endcase
   endtask

   // Raise req and hold it until ready is seen at an edge
   task automatic handshake(input port_id_t p);
      logic taken;
      taken      = 1'b0;
      req_vec[p] = 1'b1;
      while (!taken) begin
         @(negedge uhdl_common);
         taken = ready_vec[p];   // Stable since the last drive
         @(posedge uhdl_common);
         #2;
      end
      sent_cnt[p]++;
   endtask

   task automatic wait_done(input port_id_t p);
      while (done_cnt[p] != sent_cnt[p]) begin
         @(negedge uhdl_common);
      end
      @(posedge uhdl_common);
      #2;
   endtask

   task automatic complete(input port_id_t p);
      handshake(p);
      req_vec[p] = 1'b0;
      wait_done(p);
   endtask

   task automatic access(input port_id_t p, input logic wr, input mm_addr_t addr,
                         input mcr_word_t data);
      prepare(p, wr, addr, data);
      complete(p);
   endtask

   task automatic close_test(input string name, input int err_mark);
      tests_run++;
      if (errors == err_mark) begin
         $display("Test %s: ok", name);
      end else begin
         tests_failed++;
         $display("Test %s: %0d errors", name, errors - err_mark);
      end
   endtask

   initial begin
      void'($urandom(38));
      reset            = 1'b1;
      req_vec          = 4'b0000;
      vram_vga_addr    = '0;
      mcr_write        = 1'b0;
      mcr_addr         = '0;
      mcr_data_in      = '0;
      vram_cpu_write   = 1'b0;
      vram_cpu_addr    = '0;
      vram_cpu_data_in = '0;
      sdram_write      = 1'b0;
      sdram_addr       = '0;
      sdram_data_in    = '0;
      exp_data         = '0;
      chk              = 4'b0000;
      quiet_chk        = 1'b0;
      order_chk        = 1'b0;
      errors           = 0;
      tests_run        = 0;
      tests_failed     = 0;
      for (int i = 0; i < 4; i++) begin
         sent_cnt[i] = 0;
      end
      repeat (4) @(posedge uhdl_common);
      #2;
      reset = 1'b0;

      mark      = errors;
      quiet_chk = 1'b1;   // Nothing requested yet
      repeat (6) @(posedge uhdl_common);
      #2;
      quiet_chk = 1'b0;
      close_test("1 reset state", mark);

      mark = errors;
      for (int i = 0; i < MM_N; i++) begin
         mm_list[i] = mm_addr_t'($urandom());
         access(PORT_MM, 1'b1, mm_list[i], random_word32());
      end
      for (int i = 0; i < MM_N; i++) begin
         access(PORT_MM, 1'b0, mm_list[i] ^ 22'h3e0000, '0);   // Upper bits flipped, same word
      end
      close_test("2 main memory", mark);

      mark = errors;
      va   = mm_addr_t'($urandom() & 32'h7fff);
      access(PORT_VCPU, 1'b1, va, random_word32());
      access(PORT_VGA, 1'b0, va, '0);
      access(PORT_MM, 1'b1, va, random_word32());   // Same low address, other region
      access(PORT_VGA, 1'b0, va, '0);
      access(PORT_MM, 1'b0, va, '0);
      close_test("3 video regions", mark);

      mark = errors;
      for (int i = 0; i < MCR_N; i++) begin
         mcr_list[i] = mcr_addr_t'($urandom());
         access(PORT_MCR, 1'b1, mm_addr_t'(mcr_list[i]), random_word49());
      end
      for (int i = 0; i < MCR_N; i++) begin
         access(PORT_MCR, 1'b0, mm_addr_t'(mcr_list[i]), '0);
      end
      close_test("4 microcode", mark);

      mark      = errors;
      order_chk = 1'b1;
      prepare(PORT_VGA, 1'b0, va, '0);
      prepare(PORT_MCR, 1'b0, mm_addr_t'(mcr_list[0]), '0);
      prepare(PORT_VCPU, 1'b0, va, '0);
      prepare(PORT_MM, 1'b0, mm_list[0], '0);
      fork   // All four raise req in the same cycle
         complete(PORT_VGA);
         complete(PORT_MCR);
         complete(PORT_VCPU);
         complete(PORT_MM);
      join
      order_chk = 1'b0;
      close_test("5 four-port priority", mark);

      mark = errors;
      prepare(PORT_VGA, 1'b0, va, '0);
      prepare(PORT_MM, 1'b0, mm_list[1], '0);
      fork
         begin
            repeat (6) handshake(PORT_VGA);   // req never drops in between
            req_vec[PORT_VGA] = 1'b0;
            wait_done(PORT_VGA);
         end
         complete(PORT_MM);
      join
      close_test("6 held request", mark);

      $display("Summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

/* project.f */
design/mem_pkg.sv
design/port_mux.sv
design/sram_sequencer.sv
design/ram_controller.sv
verification/sram_model.sv
verification/ram_controller_tb.sv

/* Makefile */
# Verilator build of ram_controller_tb; a run passes only when the log holds the pass message

SIM := obj_dir/Vram_controller_tb

.PHONY: all run clean

all: run

# Rebuilt only when the file list or a source changes
$(SIM): project.f $(shell cat project.f)
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module ram_controller_tb -f project.f

run: $(SIM)
	./$(SIM) > sim.log 2>&1 || true
	cat sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
